// File: verilog/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DC_SETS       8
`define DC_WAYS       4

// one word per memory beat
`define DC_WORD_W     32
`define DC_LINE_WORDS 8

// tag is what is left of a 32-bit address above set and offset
`define DC_TAG_W      24

// every memory transfer moves one whole line
`define DC_BURST_LEN  8

`endif

// File: verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	typedef logic [`DC_WORD_W-1:0]                word_t;
	typedef logic [31:0]                          addr_t;
	typedef logic [`DC_WORD_W/8-1:0]              strb_t;
	typedef logic [`DC_TAG_W-1:0]                 tag_t;
	typedef logic [$clog2(`DC_SETS)-1:0]          set_t;
	typedef logic [$clog2(`DC_LINE_WORDS)-1:0]    word_sel_t;
	// one-hot, bit i selects way i
	typedef logic [`DC_WAYS-1:0]                  way_t;
	// tree bits: [0] picks the pair, [1] inside ways 0/1, [2] inside ways 2/3
	typedef logic [`DC_WAYS-2:0]                  plru_t;
	// word 0 sits in the low bits
	typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0] line_t;

	typedef struct packed {
		logic  wr;
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
	} cpu_req_t;

	typedef struct packed {
		word_t data;
		logic  last;
	} mem_beat_t;

	typedef enum logic [3:0] {
		idle, lookup, evict, wb_req, wb_data, fill_req, fill_data, refill, write, read, resp
	} cache_state_t;

endpackage

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       req_valid,
	input  wire dcache_pkg::cpu_req_t req,
	input  wire                       rsp_ready,
	input  wire                       fill_req_ready,
	input  wire                       fill_rsp_valid,
	input  wire                       fill_last,
	input  wire                       wb_req_ready,
	input  wire                       wb_data_ready,
	input  wire                       wb_last,
	input  wire                       hit,
	input  wire                       victim_dirty,
	output logic                      req_ready,
	output logic                      rsp_valid,
	output logic                      fill_req_valid,
	output logic                      fill_rsp_ready,
	output logic                      wb_req_valid,
	output logic                      wb_data_valid,
	output dcache_pkg::cpu_req_t      cur_req,
	output logic                      lookup_en,
	output logic                      evict_en,
	output logic                      refill_en,
	output logic                      write_en,
	output logic                      touch_en,
	output logic                      wb_load,
	output logic                      wb_shift,
	output logic                      fill_shift
);
	import dcache_pkg::*;

	cache_state_t state_q;
	cache_state_t state_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= idle;
		end else begin
			state_q <= state_d;
		end
	end

	// request is held for the whole miss sequence
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			cur_req <= req;
		end
	end

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			idle:      if (req_valid) state_d = lookup;
			// hit goes straight to the array, miss starts replacement
			lookup: begin
				if (!hit) begin
					state_d = evict;
				end else if (cur_req.wr) begin
					state_d = write;
				end else begin
					state_d = read;
				end
			end
			// clean victim skips the write-back burst
			evict:     state_d = victim_dirty ? wb_req : fill_req;
			wb_req:    if (wb_req_ready) state_d = wb_data;
			wb_data:   if (wb_data_ready && wb_last) state_d = fill_req;
			fill_req:  if (fill_req_ready) state_d = fill_data;
			fill_data: if (fill_rsp_valid && fill_last) state_d = refill;
			// write-allocate merges the cpu word into the new line
			refill:    state_d = cur_req.wr ? write : resp;
			write:     state_d = idle;
			read:      state_d = resp;
			resp:      if (rsp_ready) state_d = idle;
			default:   state_d = idle;
		endcase
	end

	// handshakes are pure state decodes
	assign req_ready      = (state_q == idle);
	assign rsp_valid      = (state_q == resp);
	assign fill_req_valid = (state_q == fill_req);
	assign fill_rsp_ready = (state_q == fill_data);
	assign wb_req_valid   = (state_q == wb_req);
	assign wb_data_valid  = (state_q == wb_data);

	// store strobes
	assign lookup_en = (state_q == lookup);
	assign evict_en  = (state_q == evict);
	assign refill_en = (state_q == refill);
	assign write_en  = (state_q == write);
	// a read counts as used only once the cpu takes the data
	assign touch_en  = (state_q == write) || (state_q == resp && rsp_ready);

	// victim line is stable in wb_req, so reload it every cycle there
	assign wb_load    = (state_q == wb_req);
	assign wb_shift   = (state_q == wb_data) && wb_data_ready;
	assign fill_shift = (state_q == fill_data) && fill_rsp_valid;

endmodule

`default_nettype wire

// File: verilog/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_store (
	input  wire                   clk,
	input  wire                   rst,
	input  wire dcache_pkg::tag_t tag,
	input  wire dcache_pkg::set_t set,
	input  wire                   lookup_en,
	input  wire                   evict_en,
	input  wire                   refill_en,
	input  wire                   write_en,
	input  wire                   touch_en,
	output logic                  hit,
	output logic                  victim_dirty,
	output dcache_pkg::way_t      way,
	output dcache_pkg::addr_t     wb_addr
);
	import dcache_pkg::*;

	// per set, bit i belongs to way i
	logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
	logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
	tag_t                tag_q   [`DC_SETS][`DC_WAYS];
	plru_t               plru_q  [`DC_SETS];

	way_t  hit_way;
	way_t  victim;
	plru_t plru;
	tag_t  victim_tag;
	logic  pair_lo;

	// tag compare in all ways at once
	always_comb begin
		for (int i = 0; i < `DC_WAYS; i++) begin
			hit_way[i] = valid_q[set][i] && (tag_q[set][i] == tag);
		end
	end

	assign hit = |hit_way;

	always_comb begin
		plru   = plru_q[set];
		victim = '0;
		if (!(&valid_q[set])) begin
			// walk down so the lowest invalid way wins
			for (int i = `DC_WAYS - 1; i >= 0; i--) begin
				if (!valid_q[set][i]) victim = way_t'(1) << i;
			end
		end else begin
			// pair from bit 0, then bit 1 or bit 2 inside the pair
			victim[{plru[0], plru[0] ? plru[2] : plru[1]}] = 1'b1;
		end
	end

	assign victim_dirty = |(victim & valid_q[set] & dirty_q[set]);

	// chosen-way register, hit way on lookup, victim on evict
	always_ff @(posedge clk) begin
		if (rst) begin
			way <= '0;
		end else if (lookup_en) begin
			way <= hit_way;
		end else if (evict_en) begin
			way <= victim;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (refill_en) begin
			valid_q[set] <= valid_q[set] | way;
			dirty_q[set] <= dirty_q[set] & ~way;
		end else if (write_en) begin
			dirty_q[set] <= dirty_q[set] | way;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `DC_WAYS; i++) begin
			if (refill_en && way[i]) tag_q[set][i] <= tag;
		end
	end

	// point every tree bit on the path away from the used way
	assign pair_lo = way[0] | way[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				plru_q[s] <= '0;
			end
		end else if (touch_en) begin
			plru_q[set][0] <= pair_lo;
			if (pair_lo) begin
				plru_q[set][1] <= way[0];
			end else begin
				plru_q[set][2] <= way[2];
			end
		end
	end

	// line address of the registered victim
	always_comb begin
		victim_tag = '0;
		for (int i = 0; i < `DC_WAYS; i++) begin
			if (way[i]) victim_tag = victim_tag | tag_q[set][i];
		end
	end

	assign wb_addr = {victim_tag, set, 5'b0};

endmodule

`default_nettype wire

// File: verilog/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_data_store (
	input  wire                        clk,
	input  wire dcache_pkg::set_t      set,
	input  wire dcache_pkg::word_sel_t word_sel,
	input  wire dcache_pkg::way_t      way,
	input  wire dcache_pkg::line_t     fill_line,
	input  wire dcache_pkg::word_t     wdata,
	input  wire dcache_pkg::strb_t     wstrb,
	input  wire                        refill_en,
	input  wire                        write_en,
	output dcache_pkg::line_t          line,
	output dcache_pkg::word_t          rd_word
);
	import dcache_pkg::*;

	line_t mem_q [`DC_SETS][`DC_WAYS];
	word_t merged;

	// one-hot way, so or-ing the masked lines gives the chosen one
	always_comb begin
		line = '0;
		for (int i = 0; i < `DC_WAYS; i++) begin
			if (way[i]) line = line | mem_q[set][i];
		end
	end

	assign rd_word = line[`DC_WORD_W * word_sel +: `DC_WORD_W];

	// strobed bytes from the cpu, the rest from the stored word
	always_comb begin
		for (int b = 0; b < `DC_WORD_W / 8; b++) begin
			merged[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : rd_word[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `DC_WAYS; i++) begin
			if (refill_en && way[i]) begin
				mem_q[set][i] <= fill_line;
			end else if (write_en && way[i]) begin
				mem_q[set][i][`DC_WORD_W * word_sel +: `DC_WORD_W] <= merged;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/dcache_line_xfer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_line_xfer (
	input  wire                        clk,
	input  wire                        rst,
	input  wire dcache_pkg::mem_beat_t fill_beat,
	input  wire                        fill_shift,
	input  wire                        wb_load,
	input  wire                        wb_shift,
	input  wire dcache_pkg::line_t     victim_line,
	output dcache_pkg::line_t          fill_line,
	output logic                       fill_last,
	output dcache_pkg::word_t          wb_data,
	output logic                       wb_last
);
	import dcache_pkg::*;

	line_t fill_q;
	line_t wb_q;
	// one-hot, bit k marks beat k of the write-back
	logic [`DC_BURST_LEN-1:0] beat_q;

	// new beats enter at the top, so word 0 ends at the bottom after eight
	always_ff @(posedge clk) begin
		if (fill_shift) begin
			fill_q <= {fill_beat.data, fill_q[`DC_LINE_WORDS*`DC_WORD_W-1:`DC_WORD_W]};
		end
	end

	assign fill_line = fill_q;
	assign fill_last = fill_beat.last;

	// victim leaves from the bottom, one word per accepted beat
	always_ff @(posedge clk) begin
		if (wb_load) begin
			wb_q <= victim_line;
		end else if (wb_shift) begin
			wb_q <= {{`DC_WORD_W{1'b0}}, wb_q[`DC_LINE_WORDS*`DC_WORD_W-1:`DC_WORD_W]};
		end
	end

	assign wb_data = wb_q[`DC_WORD_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_q <= '0;
		end else if (wb_load) begin
			beat_q <= {{(`DC_BURST_LEN-1){1'b0}}, 1'b1};
		end else if (wb_shift) begin
			beat_q <= beat_q << 1;
		end
	end

	// high while the eighth word is on the bus
	assign wb_last = beat_q[`DC_BURST_LEN-1];

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  wire                        clk,
	input  wire                        rst,
	// cpu request channel
	input  wire                        req_valid,
	input  wire dcache_pkg::cpu_req_t  req,
	output logic                       req_ready,
	// cpu read response channel
	output logic                       rsp_valid,
	output dcache_pkg::word_t          rsp_data,
	input  wire                        rsp_ready,
	// memory refill request and beats
	output logic                       fill_req_valid,
	output dcache_pkg::addr_t          fill_req_addr,
	input  wire                        fill_req_ready,
	input  wire                        fill_rsp_valid,
	input  wire dcache_pkg::mem_beat_t fill_rsp,
	output logic                       fill_rsp_ready,
	// memory write-back request and beats
	output logic                       wb_req_valid,
	output dcache_pkg::addr_t          wb_req_addr,
	input  wire                        wb_req_ready,
	output logic                       wb_data_valid,
	output dcache_pkg::word_t          wb_data,
	output logic                       wb_data_last,
	input  wire                        wb_data_ready
);
	import dcache_pkg::*;

	// registered request and the fields cut from its address
	cpu_req_t  cur_req;
	tag_t      req_tag;
	set_t      req_set;
	word_sel_t req_word;

	// lookup results
	logic      hit;
	logic      victim_dirty;
	way_t      way;

	// line paths between stores and burst registers
	line_t     line;
	line_t     fill_line;
	logic      fill_last;

	// one-cycle strobes from the fsm
	logic      lookup_en;
	logic      evict_en;
	logic      refill_en;
	logic      write_en;
	logic      touch_en;
	logic      wb_load;
	logic      wb_shift;
	logic      fill_shift;

	// tag 31:8, set 7:5, word 4:2
	assign req_tag  = cur_req.addr[31:8];
	assign req_set  = cur_req.addr[7:5];
	assign req_word = cur_req.addr[4:2];

	// refill always fetches the whole line
	assign fill_req_addr = {cur_req.addr[31:5], 5'b0};

	dcache_ctrl ctrl_i (
		.clk, .rst, .req_valid, .req, .rsp_ready, .fill_req_ready, .fill_rsp_valid,
		.fill_last, .wb_req_ready, .wb_data_ready, .wb_last(wb_data_last), .hit,
		.victim_dirty, .req_ready, .rsp_valid, .fill_req_valid, .fill_rsp_ready,
		.wb_req_valid, .wb_data_valid, .cur_req, .lookup_en, .evict_en, .refill_en,
		.write_en, .touch_en, .wb_load, .wb_shift, .fill_shift
	);

	dcache_tag_store tag_i (
		.clk, .rst, .tag(req_tag), .set(req_set), .lookup_en, .evict_en, .refill_en,
		.write_en, .touch_en, .hit, .victim_dirty, .way, .wb_addr(wb_req_addr)
	);

	dcache_data_store data_i (
		.clk, .set(req_set), .word_sel(req_word), .way, .fill_line,
		.wdata(cur_req.wdata), .wstrb(cur_req.wstrb), .refill_en, .write_en,
		.line, .rd_word(rsp_data)
	);

	dcache_line_xfer xfer_i (
		.clk, .rst, .fill_beat(fill_rsp), .fill_shift, .wb_load, .wb_shift,
		.victim_line(line), .fill_line, .fill_last, .wb_data, .wb_last(wb_data_last)
	);

endmodule

`default_nettype wire

// File: bench/dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts (
	input wire                    clk,
	input wire                    rst,
	input wire                    req_ready,
	input wire                    rsp_valid,
	input wire                    rsp_ready,
	input wire dcache_pkg::word_t rsp_data,
	input wire                    fill_req_valid,
	input wire                    fill_req_ready,
	input wire dcache_pkg::addr_t fill_req_addr,
	input wire                    wb_req_valid,
	input wire                    wb_req_ready,
	input wire dcache_pkg::addr_t wb_req_addr,
	input wire                    wb_data_valid,
	input wire                    wb_data_ready,
	input wire dcache_pkg::word_t wb_data,
	input wire                    wb_data_last
);
	import dcache_pkg::*;

	// beats taken since the last write-back request
	logic [3:0] beat_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (wb_req_valid && wb_req_ready) begin
			beat_cnt <= '0;
		end else if (wb_data_valid && wb_data_ready) begin
			beat_cnt <= beat_cnt + 4'd1;
		end
	end

	// idle and resp are separate states
	a_ready_rsp: assert property (@(posedge clk) disable iff (rst)
		!(req_ready && rsp_valid)) else $error("req_ready and rsp_valid both high");

	// valids hold with their payload until taken
	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else $error("rsp_valid dropped or rsp_data changed");
	a_fill_hold: assert property (@(posedge clk) disable iff (rst)
		fill_req_valid && !fill_req_ready |=> fill_req_valid && $stable(fill_req_addr))
		else $error("fill request not held");
	a_wb_req_hold: assert property (@(posedge clk) disable iff (rst)
		wb_req_valid && !wb_req_ready |=> wb_req_valid && $stable(wb_req_addr))
		else $error("write-back request not held");
	a_wb_data_hold: assert property (@(posedge clk) disable iff (rst)
		wb_data_valid && !wb_data_ready |=>
		wb_data_valid && $stable(wb_data) && $stable(wb_data_last))
		else $error("write-back beat not held");

	// last only on the eighth beat
	a_wb_last: assert property (@(posedge clk) disable iff (rst)
		wb_data_valid |-> (wb_data_last == (beat_cnt == 4'd7)))
		else $error("wb_data_last on wrong beat");

endmodule

bind dcache_top dcache_asserts asserts_i (
	.clk(clk), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready), .rsp_data(rsp_data), .fill_req_valid(fill_req_valid),
	.fill_req_ready(fill_req_ready), .fill_req_addr(fill_req_addr),
	.wb_req_valid(wb_req_valid), .wb_req_ready(wb_req_ready), .wb_req_addr(wb_req_addr),
	.wb_data_valid(wb_data_valid), .wb_data_ready(wb_data_ready), .wb_data(wb_data),
	.wb_data_last(wb_data_last)
);

`default_nettype wire

// File: bench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int N_RAND    = 380;
	// random traffic plus directed requests, 60 cycles each at worst
	localparam int MAX_CYCLE = (N_RAND + 20) * 60;

	logic      clk;
	logic      rst;
	logic      req_valid;
	cpu_req_t  req;
	logic      req_ready;
	logic      rsp_valid;
	word_t     rsp_data;
	logic      rsp_ready;
	logic      fill_req_valid;
	addr_t     fill_req_addr;
	logic      fill_req_ready;
	logic      fill_rsp_valid;
	mem_beat_t fill_rsp;
	logic      fill_rsp_ready;
	logic      wb_req_valid;
	addr_t     wb_req_addr;
	logic      wb_req_ready;
	logic      wb_data_valid;
	word_t     wb_data;
	logic      wb_data_last;
	logic      wb_data_ready;

	integer seed;
	int     errors;
	int     checks;
	int     cycles;
	// index is tag*16 + set*8 + word
	word_t  mem_words [96];
	word_t  ref_words [96];
	// memory model state
	logic   fill_pending;
	logic   fill_go;
	int     fill_base;
	int     fill_k;
	int     wb_base;
	int     wb_k;
	logic   watch_on;
	addr_t  watch_addr;
	int     prev_line;
	int     lat;

	dcache_top dut_i (
		.clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
		.fill_req_valid(fill_req_valid), .fill_req_addr(fill_req_addr),
		.fill_req_ready(fill_req_ready), .fill_rsp_valid(fill_rsp_valid),
		.fill_rsp(fill_rsp), .fill_rsp_ready(fill_rsp_ready),
		.wb_req_valid(wb_req_valid), .wb_req_addr(wb_req_addr),
		.wb_req_ready(wb_req_ready), .wb_data_valid(wb_data_valid), .wb_data(wb_data),
		.wb_data_last(wb_data_last), .wb_data_ready(wb_data_ready)
	);

	always #4 clk = ~clk;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// six tags share two sets so the four ways overflow
	function automatic addr_t pool_addr(input int ti, input int si, input int w);
		tag_t t;
		set_t s;
		t = 24'h3ca500 + tag_t'(ti * 17);
		s = (si != 0) ? 3'd5 : 3'd2;
		return {t, s, w[2:0], 2'b00};
	endfunction

	// back to the model index, -1 for an address outside the pool
	function automatic int pool_index(input addr_t a);
		int idx;
		idx = -1;
		for (int ti = 0; ti < 6; ti++) begin
			for (int si = 0; si < 2; si++) begin
				if (pool_addr(ti, si, 0) == {a[31:5], 5'b0}) idx = ti * 16 + si * 8 + a[4:2];
			end
		end
		return idx;
	endfunction

	function automatic logic chance(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	// memory model, driven on the falling edge from stable dut outputs
	always @(negedge clk) begin
		if (rst) begin
			fill_req_ready = 1'b0;
			fill_rsp_valid = 1'b0;
			fill_rsp       = '0;
			wb_req_ready   = 1'b0;
			wb_data_ready  = 1'b0;
			fill_pending   = 1'b0;
			fill_go        = 1'b0;
		end else begin
			// beat decided last time was taken on the rising edge
			if (fill_go) begin
				fill_k++;
				fill_rsp_valid = 1'b0;
				if (fill_k == 8) fill_pending = 1'b0;
			end
			if (fill_pending && !fill_rsp_valid) fill_rsp_valid = chance(70);
			fill_rsp.data = fill_pending ? mem_words[fill_base + fill_k % 8] : '0;
			fill_rsp.last = fill_pending && (fill_k == 7);
			fill_go = fill_rsp_valid && fill_rsp_ready;

			fill_req_ready = chance(60);
			if (fill_req_valid && fill_req_ready) begin
				check_addr("fill_req_addr low bits", fill_req_addr & 32'h1f, 32'h0);
				fill_base = pool_index(fill_req_addr) & ~7;
				if (pool_index(fill_req_addr) < 0) begin
					errors++;
					$display("refill request for an address outside the pool");
					fill_base = 0;
				end
				fill_pending = 1'b1;
				fill_k = 0;
			end

			wb_req_ready = chance(60);
			if (wb_req_valid && wb_req_ready) begin
				check_addr("wb_req_addr low bits", wb_req_addr & 32'h1f, 32'h0);
				if (watch_on && wb_req_addr == watch_addr) begin
					errors++;
					$display("write-back evicted the most recently used line");
				end
				wb_base = pool_index(wb_req_addr) & ~7;
				if (pool_index(wb_req_addr) < 0) begin
					errors++;
					$display("write-back to an address outside the pool");
					wb_base = 0;
				end
				wb_k = 0;
			end

			wb_data_ready = chance(65);
			if (wb_data_valid && wb_data_ready) begin
				check_word("wb_data", wb_data, ref_words[wb_base + wb_k % 8]);
				check_bit("wb_data_last", wb_data_last, wb_k == 7);
				mem_words[wb_base + wb_k % 8] = wb_data;
				wb_k++;
			end
		end
	end

	// one cpu request, lat counts falling edges from acceptance to rsp_valid
	task automatic access(input logic wr, input int ti, input int si, input int w,
			input word_t d, input strb_t s, output int lat_out);
		int    idx;
		word_t old;
		idx = ti * 16 + si * 8 + w;
		@(negedge clk);
		req_valid = 1'b1;
		req.wr    = wr;
		req.addr  = pool_addr(ti, si, w);
		req.wdata = d;
		req.wstrb = s;
		while (!req_ready) @(negedge clk);
		// accepted on the next rising edge
		if (wr) begin
			old = ref_words[idx];
			for (int b = 0; b < 4; b++) begin
				ref_words[idx][8*b +: 8] = s[b] ? d[8*b +: 8] : old[8*b +: 8];
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
		lat_out = 1;
		if (!wr) begin
			while (!rsp_valid) begin
				@(negedge clk);
				lat_out++;
			end
			rsp_ready = chance(60);
			while (!rsp_ready) begin
				@(negedge clk);
				rsp_ready = chance(60);
			end
			check_word("rsp_data", rsp_data, ref_words[idx]);
			@(negedge clk);
			rsp_ready = 1'b0;
		end
		prev_line = ti * 2 + si;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLE) begin
			$display("timeout after %0d cycles, the cache stopped answering", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int    ti;
		int    si;
		int    w;
		logic  wr;
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		fill_req_ready = 1'b0;
		fill_rsp_valid = 1'b0;
		fill_rsp = '0;
		wb_req_ready = 1'b0;
		wb_data_ready = 1'b0;
		seed = 32'ha181_b638;
		errors = 0;
		checks = 0;
		cycles = 0;
		watch_on = 1'b0;
		watch_addr = '0;
		prev_line = -1;
		// pattern mixes every address bit
		for (int i = 0; i < 96; i++) begin
			mem_words[i] = (pool_addr(i / 16, (i / 8) % 2, i % 8) * 32'h9e3779b1) ^ 32'hc3a50f1e;
			ref_words[i] = mem_words[i];
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_bit("req_ready", req_ready, 1'b1);
		check_bit("rsp_valid", rsp_valid, 1'b0);
		check_bit("fill_req_valid", fill_req_valid, 1'b0);
		check_bit("wb_req_valid", wb_req_valid, 1'b0);

		// fill all four ways, make tag 0 dirty and newest, then force a miss
		for (int t = 0; t < 4; t++) access(1'b0, t, 0, t, '0, '0, lat);
		access(1'b1, 0, 0, 1, 32'h1234_5678, 4'hf, lat);
		watch_addr = pool_addr(0, 0, 0);
		watch_on = 1'b1;
		access(1'b0, 4, 0, 2, '0, '0, lat);
		watch_on = 1'b0;
		access(1'b0, 0, 0, 1, '0, '0, lat);
		check_word("plru hit latency", word_t'(lat), 32'd3);

		for (int n = 0; n < N_RAND; n++) begin
			ti = $unsigned($random(seed)) % 6;
			si = $unsigned($random(seed)) % 2;
			w  = $unsigned($random(seed)) % 8;
			wr = chance(45);
			// same line as last time gives a hit of fixed latency
			if (!wr && prev_line == ti * 2 + si) begin
				access(wr, ti, si, w, $random(seed), $random(seed), lat);
				check_word("read hit latency", word_t'(lat), 32'd3);
			end else begin
				access(wr, ti, si, w, $random(seed), $random(seed), lat);
			end
		end
		repeat (4) @(negedge clk);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_line_xfer.sv
verilog/dcache_top.sv
bench/dcache_asserts.sv
bench/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

verilator --binary --timing -Wno-fatal -Iverilog --top-module dcache_tb \
	-f all.f -o dcache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
